//--- verilog/bubble_pkg.sv
package bubble_pkg;

    typedef enum logic
    {
        page,
        bootloader
    } load_kind_t;

    typedef enum logic [3:0]
    {
        standby,
        load_address,
        chip_enable,
        instruction_shift,
        instruction_wait,
        buffer_write,
        odd_bit_in,
        address_increment,
        even_bit_in,
        quit
    } loader_state_t;

    localparam logic [7:0]  flash_read_opcode = 8'h03;   // W25Q plain read
    localparam logic [11:0] bootloader_page   = 12'h805; // First bootloader page

    // Sequence landmarks, in master_clock cycles
    localparam int standby_cycles     = 62;
    localparam int instruction_cycles = 64;  // 32 bits, two cycles each
    localparam int pair_cycles        = 4;
    localparam int trailing_cycles    = 8;   // Finishes the last write

    localparam int page_pairs       = 512;   // 128 bytes
    localparam int bootloader_pairs = 1920;  // 480 bytes

endpackage

//--- verilog/buffer_write_if.sv
`timescale 1ns/10ps

interface buffer_write_if #(
    parameter int buffer_addr_width = 11
);

    logic [buffer_addr_width-1:0] address;
    logic [1:0]                   data;    // Bubble pair, first bit in [1]
    logic                         write;
    logic                         done;    // One cycle at end of load

    modport loader
    (
        output address,
        output data,
        output write,
        output done
    );

    modport buffer
    (
        input address,
        input data,
        input write
    );

    modport control
    (
        input done
    );

endinterface

//--- verilog/load_control.sv
`timescale 1ns/10ps

module load_control
(
    input  logic                   master_clock,
    input  logic                   rst_n,
    input  logic                   load_page,
    input  logic                   load_bootloader,
    input  logic [2:0]             image_number,
    input  logic [11:0]            bubble_page,
    output logic                   start,
    output bubble_pkg::load_kind_t kind,
    output logic [2:0]             image,
    output logic [11:0]            page,
    output logic                   busy,
    buffer_write_if.control        wr
);

    typedef enum logic
    {
        ctrl_idle,
        ctrl_busy
    } ctrl_state_t;

    ctrl_state_t state;
    logic        accept;

    // Commands only count while no load runs
    assign accept = (state == ctrl_idle) && (load_page || load_bootloader);
    assign busy   = (state == ctrl_busy);

    always_ff @(posedge master_clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= ctrl_idle;
            start <= 1'b0;
            kind  <= bubble_pkg::page;
        end
        else
        begin
            start <= accept;
            case (state)
                ctrl_idle:
                begin
                    if (accept)
                    begin
                        state <= ctrl_busy;
                        kind  <= load_bootloader ? bubble_pkg::bootloader
                                                 : bubble_pkg::page; // Bootloader wins
                    end
                end
                ctrl_busy:
                begin
                    if (wr.done)
                    begin
                        state <= ctrl_idle;
                    end
                end
                default:
                begin
                    state <= ctrl_idle;
                end
            endcase
        end
    end

    // Address fields held for the whole load
    always_ff @(posedge master_clock)
    begin
        if (accept)
        begin
            image <= image_number;
            page  <= load_bootloader ? bubble_pkg::bootloader_page : bubble_page;
        end
    end

endmodule

//--- verilog/page_loader.sv
`timescale 1ns/10ps

module page_loader #(
    parameter int buffer_addr_width = 11
)
(
    input  logic                   master_clock,
    input  logic                   rst_n,
    input  logic                   start,
    input  bubble_pkg::load_kind_t kind,
    input  logic [2:0]             image,
    input  logic [11:0]            page,
    output logic                   spi_cs_n,
    output logic                   spi_clk,
    output logic                   spi_mosi,
    input  logic                   spi_miso,
    buffer_write_if.loader         wr
);

    localparam logic [12:0] address_count = 13'(bubble_pkg::standby_cycles);
    localparam logic [12:0] enable_count  = 13'(bubble_pkg::standby_cycles + 1);
    localparam logic [12:0] data_count    = 13'(bubble_pkg::standby_cycles + 2
                                                + bubble_pkg::instruction_cycles);
    localparam logic [12:0] page_length   = 13'(bubble_pkg::page_pairs
                                                * bubble_pkg::pair_cycles);
    localparam logic [12:0] boot_length   = 13'(bubble_pkg::bootloader_pairs
                                                * bubble_pkg::pair_cycles);

    logic                      running;
    logic [12:0]               seq_count;
    logic [12:0]               data_end;
    logic [12:0]               quit_count;
    bubble_pkg::loader_state_t state;
    bubble_pkg::loader_state_t next_state;
    logic                      capture_en;
    logic                      pair_ready;
    logic [32:0]               shift_reg;   // Spare bit + opcode + 24-bit address

    assign spi_mosi = shift_reg[32];

    assign data_end   = data_count + ((kind == bubble_pkg::bootloader) ? boot_length
                                                                      : page_length);
    assign quit_count = data_end + 13'(bubble_pkg::trailing_cycles);

    always_ff @(posedge master_clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            running   <= 1'b0;
            seq_count <= '0;
        end
        else if (start)
        begin
            running   <= 1'b1;
            seq_count <= '0;
        end
        else if (running)
        begin
            if (seq_count == quit_count)
            begin
                running   <= 1'b0;
                seq_count <= '0;
            end
            else
            begin
                seq_count <= seq_count + 13'd1;
            end
        end
    end

    // Counter landmarks to sequence step
    always_comb
    begin
        if (!running)
        begin
            next_state = bubble_pkg::standby;
        end
        else if (seq_count < address_count)
        begin
            next_state = bubble_pkg::standby;
        end
        else if (seq_count == address_count)
        begin
            next_state = bubble_pkg::load_address;
        end
        else if (seq_count == enable_count)
        begin
            next_state = bubble_pkg::chip_enable;
        end
        else if (seq_count < data_count)
        begin
            next_state = seq_count[0] ? bubble_pkg::instruction_wait
                                      : bubble_pkg::instruction_shift;
        end
        else if (seq_count < quit_count)
        begin
            case (seq_count[1:0])
                2'b00:   next_state = bubble_pkg::buffer_write;
                2'b01:   next_state = bubble_pkg::odd_bit_in;
                2'b10:   next_state = bubble_pkg::address_increment;
                default: next_state = bubble_pkg::even_bit_in;
            endcase
        end
        else
        begin
            next_state = bubble_pkg::quit;
        end
    end

    always_ff @(posedge master_clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= bubble_pkg::standby;
            capture_en <= 1'b0;
        end
        else
        begin
            state      <= next_state;
            capture_en <= running && (seq_count < data_end); // Off in trailing cycles
        end
    end

    // SPI mode 3: clock idles high, flash samples on rising edge
    always_ff @(posedge master_clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            shift_reg  <= '0;
            spi_cs_n   <= 1'b1;
            spi_clk    <= 1'b1;
            wr.address <= '1;
            wr.write   <= 1'b0;
            wr.done    <= 1'b0;
            pair_ready <= 1'b0;
        end
        else
        begin
            wr.write <= 1'b0;
            wr.done  <= 1'b0;
            case (state)
                bubble_pkg::load_address:
                begin
                    shift_reg <= {1'b0, bubble_pkg::flash_read_opcode,
                                  2'b00, image, page, 7'b000_0000};
                end
                bubble_pkg::chip_enable:
                begin
                    spi_cs_n <= 1'b0;
                end
                bubble_pkg::instruction_shift:
                begin
                    shift_reg <= shift_reg << 1; // New bit on the falling edge
                    spi_clk   <= ~spi_clk;
                end
                bubble_pkg::instruction_wait:
                begin
                    spi_clk <= ~spi_clk;
                end
                bubble_pkg::buffer_write:
                begin
                    shift_reg  <= '0;
                    spi_clk    <= ~spi_clk;
                    wr.write   <= pair_ready; // Previous pair complete
                    pair_ready <= 1'b0;
                end
                bubble_pkg::odd_bit_in:
                begin
                    spi_clk <= ~spi_clk;
                end
                bubble_pkg::address_increment:
                begin
                    spi_clk <= ~spi_clk;
                    if (capture_en)
                    begin
                        wr.address <= wr.address + 1'b1; // All-ones wraps to 0
                    end
                end
                bubble_pkg::even_bit_in:
                begin
                    spi_clk <= ~spi_clk;
                    if (capture_en)
                    begin
                        pair_ready <= 1'b1;
                    end
                end
                bubble_pkg::quit:
                begin
                    spi_cs_n <= 1'b1;
                    spi_clk  <= 1'b1;
                    wr.done  <= 1'b1;
                end
                default:
                begin
                    shift_reg  <= '0;
                    spi_cs_n   <= 1'b1;
                    spi_clk    <= 1'b1;
                    wr.address <= '1;
                    pair_ready <= 1'b0;
                end
            endcase
        end
    end

    // MISO sampled on the rising SPI edges of each pair
    always_ff @(posedge master_clock)
    begin
        if (capture_en && (state == bubble_pkg::odd_bit_in))
        begin
            wr.data[1] <= spi_miso;
        end
        if (capture_en && (state == bubble_pkg::even_bit_in))
        begin
            wr.data[0] <= spi_miso;
        end
    end

endmodule

//--- verilog/page_buffer.sv
`timescale 1ns/10ps

module page_buffer #(
    parameter int buffer_addr_width = 11
)
(
    input  logic                         master_clock,
    buffer_write_if.buffer               wr,
    input  logic [buffer_addr_width-1:0] read_address,
    output logic [1:0]                   read_data
);

    localparam int depth = 2 ** buffer_addr_width;

    logic [1:0] mem [depth];

    always_ff @(posedge master_clock)
    begin
        if (wr.write)
        begin
            mem[wr.address] <= wr.data;
        end
    end

    // One cycle read latency
    always_ff @(posedge master_clock)
    begin
        read_data <= mem[read_address];
    end

endmodule

//--- verilog/bubble_loader_top.sv
`timescale 1ns/10ps

module bubble_loader_top #(
    parameter int buffer_addr_width = 11
)
(
    input  logic                         master_clock,
    input  logic                         rst_n,
    input  logic                         load_page,
    input  logic                         load_bootloader,
    input  logic [2:0]                   image_number,
    input  logic [11:0]                  bubble_page,
    output logic                         busy,
    input  logic [buffer_addr_width-1:0] read_address,
    output logic [1:0]                   read_data,
    output logic                         spi_cs_n,
    output logic                         spi_clk,
    output logic                         spi_mosi,
    input  logic                         spi_miso
);

    logic                   start;
    bubble_pkg::load_kind_t kind;
    logic [2:0]             image;
    logic [11:0]            page;

    buffer_write_if #(.buffer_addr_width(buffer_addr_width)) bw_if ();

    load_control i_load_control
    (
        .master_clock    (master_clock),
        .rst_n           (rst_n),
        .load_page       (load_page),
        .load_bootloader (load_bootloader),
        .image_number    (image_number),
        .bubble_page     (bubble_page),
        .start           (start),
        .kind            (kind),
        .image           (image),
        .page            (page),
        .busy            (busy),
        .wr              (bw_if.control)
    );

    page_loader #(.buffer_addr_width(buffer_addr_width)) i_page_loader
    (
        .master_clock (master_clock),
        .rst_n        (rst_n),
        .start        (start),
        .kind         (kind),
        .image        (image),
        .page         (page),
        .spi_cs_n     (spi_cs_n),
        .spi_clk      (spi_clk),
        .spi_mosi     (spi_mosi),
        .spi_miso     (spi_miso),
        .wr           (bw_if.loader)
    );

    page_buffer #(.buffer_addr_width(buffer_addr_width)) i_page_buffer
    (
        .master_clock (master_clock),
        .wr           (bw_if.buffer),
        .read_address (read_address),
        .read_data    (read_data)
    );

endmodule

//--- sim/spi_flash_model.sv
`timescale 1ns/10ps

module spi_flash_model
(
    input  logic        spi_cs_n,
    input  logic        spi_clk,
    input  logic        spi_mosi,
    output logic        spi_miso,
    output logic [31:0] last_instruction
);

    logic [31:0] shift_in;
    logic [23:0] read_address;
    logic [7:0]  data_byte;
    int unsigned bit_count;     // Instruction bits captured so far
    int unsigned data_index;    // Data bits already sent

    // Content rule of the emulated image
    function automatic logic [7:0] byte_at(input logic [23:0] address);
        return address[7:0] ^ address[15:8] ^ address[23:16] ^ 8'ha5;
    endfunction

    initial
    begin
        spi_miso         = 1'b0;
        last_instruction = '0;
        shift_in         = '0;
        read_address     = '0;
        bit_count        = 0;
        data_index       = 0;
    end

    // New transaction on chip select
    always @(negedge spi_cs_n)
    begin
        bit_count  = 0;
        data_index = 0;
        shift_in   = '0;
    end

    // Mode 3 capture on rising SPI clock
    always @(posedge spi_clk)
    begin
        if (!spi_cs_n && (bit_count < 32))
        begin
            shift_in  = {shift_in[30:0], spi_mosi};
            bit_count = bit_count + 1;
            if (bit_count == 32)
            begin
                last_instruction = shift_in;
                read_address     = shift_in[23:0];
            end
        end
    end

    // Data MSB first after each falling edge, only for the read opcode
    always @(negedge spi_clk)
    begin
        if (!spi_cs_n && (bit_count == 32) && (last_instruction[31:24] == 8'h03))
        begin
            data_byte  = byte_at(read_address + 24'(data_index / 8));
            spi_miso   <= data_byte[7 - (data_index % 8)];
            data_index = data_index + 1;
        end
    end

endmodule

//--- sim/tb_bubble_loader.sv
`timescale 1ns/10ps

module tb_bubble_loader;

    localparam int          timeout_cycles = 10000;
    localparam logic [7:0]  read_opcode    = 8'h03;
    localparam logic [11:0] boot_page      = 12'h805;

    logic        master_clock;
    logic        rst_n;
    logic        load_page;
    logic        load_bootloader;
    logic [2:0]  image_number;
    logic [11:0] bubble_page;
    logic        busy;
    logic [10:0] read_address;
    logic [1:0]  read_data;
    logic        spi_cs_n;
    logic        spi_clk;
    logic        spi_mosi;
    logic        spi_miso;
    logic [31:0] last_instruction;

    // Buffer sweep state shared with the compare process
    logic        sweep_active;
    logic        compare_valid;
    logic [10:0] compare_address;
    logic [23:0] sweep_base;
    logic [1:0]  expected_pair;
    string       test_name;

    logic [2:0]  page_image;
    logic [11:0] page_number;
    logic [2:0]  boot_image;
    logic [23:0] boot_base;

    bubble_loader_top i_bubble_loader_top
    (
        .master_clock    (master_clock),
        .rst_n           (rst_n),
        .load_page       (load_page),
        .load_bootloader (load_bootloader),
        .image_number    (image_number),
        .bubble_page     (bubble_page),
        .busy            (busy),
        .read_address    (read_address),
        .read_data       (read_data),
        .spi_cs_n        (spi_cs_n),
        .spi_clk         (spi_clk),
        .spi_mosi        (spi_mosi),
        .spi_miso        (spi_miso)
    );

    spi_flash_model i_spi_flash_model
    (
        .spi_cs_n         (spi_cs_n),
        .spi_clk          (spi_clk),
        .spi_mosi         (spi_mosi),
        .spi_miso         (spi_miso),
        .last_instruction (last_instruction)
    );

    initial
    begin
        master_clock = 1'b0;
        forever #50 master_clock = ~master_clock;
    end

    function automatic logic [23:0] flash_address(input logic [2:0] image,
                                                  input logic [11:0] page);
        return {2'b00, image, page, 7'b000_0000};
    endfunction

    // Expected pair for a buffer entry with the first pair from bits 7:6
    function automatic logic [1:0] flash_pair(input logic [23:0] base,
                                              input int unsigned index);
        logic [23:0] address;
        logic [7:0]  data_byte;
        int          pos;
        address   = base + 24'(index / 4);
        data_byte = address[7:0] ^ address[15:8] ^ address[23:16] ^ 8'ha5;
        pos       = 6 - 2 * int'(index % 4);
        return data_byte[pos +: 2];
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped");
    endtask

    task automatic issue_command(input logic boot, input logic [2:0] image,
                                 input logic [11:0] page);
        @(posedge master_clock);
        image_number    <= image;
        bubble_page     <= page;
        load_page       <= ~boot;
        load_bootloader <= boot;
        @(posedge master_clock);
        load_page       <= 1'b0;
        load_bootloader <= 1'b0;
    endtask

    task automatic wait_for_busy(input logic level);
        int cycles;
        cycles = 0;
        @(negedge master_clock);
        while (busy !== level)
        begin
            if (cycles >= timeout_cycles)
            begin
                abort_run($sformatf("Timeout: busy never went to %0b", level));
            end
            @(negedge master_clock);
            cycles++;
        end
    endtask

    task automatic load_and_wait(input logic boot, input logic [2:0] image,
                                 input logic [11:0] page);
        issue_command(boot, image, page);
        wait_for_busy(1'b1);
        wait_for_busy(1'b0);
    endtask

    task automatic check_instruction(input string name, input logic [31:0] expected);
        @(negedge master_clock);
        assert (last_instruction === expected)
        else
        begin
            abort_run($sformatf("[FAIL] %s: expected %h, actual %h",
                                name, expected, last_instruction));
        end
    endtask

    // Reads entries first..last for the compare process
    task automatic sweep_buffer(input string name, input logic [23:0] base,
                                input int first, input int last);
        test_name  = name;
        sweep_base = base;
        for (int i = first; i <= last; i++)
        begin
            @(posedge master_clock);
            read_address <= 11'(i);
            sweep_active <= 1'b1;
        end
        @(posedge master_clock);
        sweep_active <= 1'b0;
        repeat (2) @(posedge master_clock);
    endtask

    // Read data lags the address by one cycle
    always @(posedge master_clock)
    begin
        compare_valid   <= sweep_active;
        compare_address <= read_address;
    end

    always @(negedge master_clock)
    begin
        if (compare_valid)
        begin
            expected_pair = flash_pair(sweep_base, 32'(compare_address));
            assert (read_data === expected_pair)
            else
            begin
                abort_run($sformatf("[FAIL] %s entry %0d: expected %0d, actual %0d",
                                    test_name, compare_address, expected_pair, read_data));
            end
        end
    end

    initial
    begin
        void'($urandom(32'hd854));
        rst_n           = 1'b0;
        load_page       = 1'b0;
        load_bootloader = 1'b0;
        image_number    = '0;
        bubble_page     = '0;
        read_address    = '0;
        sweep_active    = 1'b0;
        compare_valid   = 1'b0;
        compare_address = '0;
        sweep_base      = '0;
        test_name       = "";
        repeat (2) @(posedge master_clock);
        rst_n <= 1'b1;

        @(negedge master_clock);
        assert ((spi_cs_n === 1'b1) && (spi_clk === 1'b1) && (spi_mosi === 1'b0)
                && (busy === 1'b0))
        else
        begin
            abort_run("SPI lines or busy not idle after reset");
        end

        page_image  = 3'($urandom);
        page_number = 12'($urandom);
        load_and_wait(1'b0, page_image, page_number);
        check_instruction("page_instruction",
                          {read_opcode, flash_address(page_image, page_number)});
        sweep_buffer("page_content", flash_address(page_image, page_number), 0, 511);

        // Page input must be replaced by the bootloader page
        boot_image = 3'($urandom);
        boot_base  = flash_address(boot_image, boot_page);
        load_and_wait(1'b1, boot_image, 12'($urandom));
        check_instruction("boot_instruction", {read_opcode, boot_base});
        sweep_buffer("boot_content", boot_base, 0, 1919);

        page_image  = 3'($urandom);
        page_number = 12'($urandom);
        load_and_wait(1'b0, page_image, page_number);
        check_instruction("page_after_boot_instruction",
                          {read_opcode, flash_address(page_image, page_number)});
        sweep_buffer("page_after_boot_low", flash_address(page_image, page_number), 0, 511);
        sweep_buffer("page_after_boot_high", boot_base, 512, 1919);

        // Bootloader command during a page load must be dropped
        page_image  = 3'($urandom);
        page_number = 12'($urandom);
        issue_command(1'b0, page_image, page_number);
        wait_for_busy(1'b1);
        issue_command(1'b1, boot_image + 3'd1, 12'($urandom));
        wait_for_busy(1'b0);
        repeat (4)
        begin
            @(negedge master_clock);
            assert (busy === 1'b0)
            else
            begin
                abort_run("Command issued while busy started a second load");
            end
        end
        check_instruction("ignored_instruction",
                          {read_opcode, flash_address(page_image, page_number)});
        sweep_buffer("ignored_low", flash_address(page_image, page_number), 0, 511);
        sweep_buffer("ignored_high", boot_base, 512, 1919);

        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- tb.f
verilog/bubble_pkg.sv
verilog/buffer_write_if.sv
verilog/load_control.sv
verilog/page_loader.sv
verilog/page_buffer.sv
verilog/bubble_loader_top.sv
sim/spi_flash_model.sv
sim/tb_bubble_loader.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_bubble_loader
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
